// File: build.f
+incdir+logic
logic/bcd_conv_pkg.sv
logic/conv_ctrl_if.sv
logic/bcd_wb_decode.sv
logic/bcd_conv_control.sv
logic/bcd_shift_datapath.sv
logic/bcd_result_regs.sv
logic/bcd2bin_top.sv
test/bcd2bin_tb.sv

// File: test/bcd2bin_tb.sv
`timescale 1ns/10ps

`include "bcd_conv_macros.svh"

module bcd2bin_tb;

  localparam int NUM_RANDOM      = 30;
  localparam int NUM_CONV        = 40;
  localparam int CYCLES_PER_CONV = 70;
  localparam int TIMEOUT_CYCLES  = NUM_CONV * CYCLES_PER_CONV + 1000;

  // busy may last up to 65 cycles, and status is only seen every other cycle.
  localparam int LATENCY_MAX = 65;
  localparam int POLL_SLACK  = 4;

  localparam logic [15:0] ST_BUSY  = 16'h0004;
  localparam logic [15:0] ST_DONE  = 16'h0002;
  localparam logic [15:0] ST_ERROR = 16'h0001;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack;

  integer      seed = 21212;
  int          cycle_cnt = 0;
  logic [15:0] last_word;
  int          last_result;

  bcd2bin_top dut (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic report_failure(input string msg);
    $display("error at time %0t: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopping at the first failure");
  endtask

  // ack comes exactly one cycle after a request, for one cycle only.
  ack_after_request: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else report_failure("wb_ack did not follow a request by one cycle");

  ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_ack |=> !wb_ack)
    else report_failure("wb_ack stayed high for more than one cycle");

  ack_needs_request: assert property (@(posedge clk) disable iff (rst)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else report_failure("wb_ack rose without a request");

  function automatic int bcd_to_int(input logic [15:0] w);
    int v;
    v = 0;
    for (int d = 3; d >= 0; d--) begin
      v = v * 10 + w[4*d +: 4];
    end
    return v;
  endfunction

  function automatic logic [15:0] random_bcd();
    logic [15:0] w;
    w = '0;
    for (int d = 0; d < 4; d++) begin
      w[4*d +: 4] = 4'(($random(seed) & 32'h7fff_ffff) % 10);
    end
    return w;
  endfunction

  task automatic write_reg(input logic [1:0] adr, input logic [15:0] data);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_i = data;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] adr, output logic [15:0] data);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    data   = wb_dat_o;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // polls status until done and not busy; the first poll must show busy alone.
  task automatic wait_done(input int t0, output logic [15:0] st);
    logic first;
    int   elapsed;
    first = 1'b1;
    do begin
      read_reg(`ADDR_STATUS, st);
      if (first) begin
        assert (st == ST_BUSY)
          else report_failure($sformatf("status %h after start, expected busy", st));
        first = 1'b0;
      end
    end while (st[2] || !st[1]);
    elapsed = cycle_cnt - t0;
    assert (elapsed <= LATENCY_MAX + POLL_SLACK)
      else report_failure($sformatf("busy lasted %0d cycles", elapsed));
  endtask

  task automatic check_regs(input logic [15:0] st_exp, input int res_exp,
                            input logic [15:0] data_exp);
    logic [15:0] rd;
    read_reg(`ADDR_STATUS, rd);
    assert (rd == st_exp)
      else report_failure($sformatf("status %h, expected %h", rd, st_exp));
    read_reg(`ADDR_RESULT, rd);
    assert (rd == 16'(res_exp))
      else report_failure($sformatf("result %0d, expected %0d", rd, res_exp));
    read_reg(`ADDR_DATA, rd);
    assert (rd == data_exp)
      else report_failure($sformatf("data register %h, expected %h", rd, data_exp));
  endtask

  task automatic run_conversion(input logic [15:0] word);
    logic [15:0] st;
    int          t0;
    write_reg(`ADDR_DATA, word);
    t0 = cycle_cnt;
    wait_done(t0, st);
    last_word   = word;
    last_result = bcd_to_int(word);
    check_regs(ST_DONE, last_result, last_word);
  endtask

  initial begin
    logic [15:0] rd;
    logic [15:0] bad;
    int          t0;

    clk      = 1'b0;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_i = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    read_reg(`ADDR_STATUS, rd);
    assert (rd == 16'h0000)
      else report_failure($sformatf("status %h after reset, expected 0", rd));
    read_reg(`ADDR_DATA, rd);
    assert (rd == 16'h0000)
      else report_failure($sformatf("data register %h after reset, expected 0", rd));

    run_conversion(16'h0000);
    run_conversion(16'h9999);
    run_conversion(16'h1234);
    run_conversion(16'h8080);

    // an out-of-range digit in each position is rejected.
    for (int pos = 0; pos < 4; pos++) begin
      bad = 16'h5555;
      bad[4*pos +: 4] = 4'hA + 4'(pos);
      write_reg(`ADDR_DATA, bad);
      check_regs(ST_DONE | ST_ERROR, last_result, last_word);
    end

    // writes during a conversion are dropped, valid or not.
    write_reg(`ADDR_DATA, 16'h4321);
    t0 = cycle_cnt;
    write_reg(`ADDR_DATA, 16'h5555);
    write_reg(`ADDR_DATA, 16'h9A99);
    wait_done(t0, rd);
    last_word   = 16'h4321;
    last_result = 4321;
    check_regs(ST_DONE, last_result, last_word);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      run_conversion(random_bcd());
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: logic/bcd2bin_top.sv
`timescale 1ns/10ps

`include "bcd_conv_macros.svh"

module bcd2bin_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [`WB_ADR_W-1:0] wb_adr,
  input  logic [`WB_DAT_W-1:0] wb_dat_i,
  output logic [`WB_DAT_W-1:0] wb_dat_o,
  output logic                 wb_ack
);

  import bcd_conv_pkg::*;

  logic              start;
  logic              bad_digit;
  logic              finish;
  logic              busy;
  logic [`BCD_W-1:0] bcd_word;
  logic [`BIN_W-1:0] bin_value;
  logic [`BIN_W-1:0] result;
  status_t           status;

  conv_ctrl_if ctl_if ();

  bcd_wb_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .busy      (busy),
    .status    (status),
    .result    (result),
    .start     (start),
    .bad_digit (bad_digit),
    .bcd_word  (bcd_word)
  );

  bcd_conv_control u_control (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .finish (finish),
    .ctl    (ctl_if.control)
  );

  bcd_shift_datapath u_datapath (
    .clk       (clk),
    .rst       (rst),
    .bcd_word  (bcd_word),
    .bin_value (bin_value),
    .ctl       (ctl_if.datapath)
  );

  bcd_result_regs u_result (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .finish    (finish),
    .bad_digit (bad_digit),
    .bin_value (bin_value),
    .busy      (busy),
    .status    (status),
    .result    (result)
  );

endmodule

// File: logic/bcd_result_regs.sv
`timescale 1ns/10ps

`include "bcd_conv_macros.svh"

module bcd_result_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  finish,
  input  logic                  bad_digit,
  input  logic [`BIN_W-1:0]     bin_value,
  output logic                  busy,
  output bcd_conv_pkg::status_t status,
  output logic [`BIN_W-1:0]     result
);

  logic done_q;
  logic error_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      done_q  <= 1'b0;
      error_q <= 1'b0;
    end else begin
      if (start) begin
        busy <= 1'b1;
      end else if (finish) begin
        busy <= 1'b0;
      end

      // done stays up until the next conversion starts.
      if (start) begin
        done_q <= 1'b0;
      end else if (finish) begin
        done_q <= 1'b1;
      end

      if (bad_digit) begin
        error_q <= 1'b1;
      end else if (start) begin
        error_q <= 1'b0;
      end
    end
  end

  // a rejected word leaves the last result in place.
  always_ff @(posedge clk) begin
    if (finish) begin
      result <= bin_value;
    end
  end

  assign status.busy  = busy;
  assign status.done  = done_q;
  assign status.error = error_q;

endmodule

// File: logic/bcd_shift_datapath.sv
`timescale 1ns/10ps

`include "bcd_conv_macros.svh"

module bcd_shift_datapath (
  input  logic              clk,
  input  logic              rst,
  input  logic [`BCD_W-1:0] bcd_word,
  output logic [`BIN_W-1:0] bin_value,
  conv_ctrl_if.datapath     ctl
);

  // upper half holds the BCD digits, lower half collects the binary bits
  // as they fall out of the bottom digit.
  logic [2*`BCD_W-1:0] sr;
  logic [2*`BCD_W-1:0] sr_fixed;
  logic                any_big;

  // every digit of 8 or more gets 3 taken off.
  always_comb begin
    sr_fixed = sr;
    any_big  = 1'b0;
    for (int d = 0; d < `BCD_DIGITS; d++) begin
      if (sr[`BCD_W + 4*d + 3]) begin
        sr_fixed[`BCD_W + 4*d +: 4] = sr[`BCD_W + 4*d +: 4] - 4'd3;
        any_big = 1'b1;
      end
    end
  end

  assign ctl.need_fix = any_big;

  // load wins over clear since both are raised in the idle state.
  always_ff @(posedge clk) begin
    if (rst) begin
      sr <= '0;
    end else if (ctl.load) begin
      sr <= {bcd_word, {`BCD_W{1'b0}}};
    end else if (ctl.clear) begin
      sr <= '0;
    end else if (ctl.shift) begin
      sr <= sr >> 1;
    end else if (ctl.correct) begin
      sr <= sr_fixed;
    end
  end

  // after the last shift the binary value sits in the low bits.
  assign bin_value = sr[`BIN_W-1:0];

endmodule

// File: logic/bcd_conv_control.sv
`timescale 1ns/10ps

`include "bcd_conv_macros.svh"

module bcd_conv_control (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  output logic        finish,
  conv_ctrl_if.control ctl
);

  import bcd_conv_pkg::*;

  conv_state_t state;
  conv_state_t next_state;
  logic [`ITER_W-1:0] iter_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= START;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    case (state)
      START:   next_state = start ? SHIFT : START;
      SHIFT:   next_state = CHECK;
      CHECK:   next_state = ctl.need_fix ? CORRECT : ITER;
      CORRECT: next_state = ITER;
      ITER:    next_state = ctl.last ? DONE : SHIFT;
      DONE:    next_state = START;
      default: next_state = START;
    endcase
  end

  // the count is reloaded while idle and drops once per iteration.
  always_ff @(posedge clk) begin
    if (rst) begin
      iter_cnt <= '0;
    end else if (state == START) begin
      iter_cnt <= `ITER_W'(`ITERS);
    end else if (ctl.iter_done) begin
      iter_cnt <= iter_cnt - 1'b1;
    end
  end

  assign ctl.last = (iter_cnt == `ITER_W'(1));

  always_comb begin
    ctl.clear     = 1'b0;
    ctl.load      = 1'b0;
    ctl.shift     = 1'b0;
    ctl.correct   = 1'b0;
    ctl.iter_done = 1'b0;
    finish        = 1'b0;
    case (state)
      START: begin
        ctl.clear = 1'b1;
        ctl.load  = start;
      end
      SHIFT: begin
        ctl.shift = 1'b1;
      end
      CHECK: begin
        // need_fix settles here from the shifted register.
      end
      CORRECT: begin
        ctl.correct = 1'b1;
      end
      ITER: begin
        ctl.iter_done = 1'b1;
      end
      DONE: begin
        finish = 1'b1;
      end
      default: begin
        ctl.clear = 1'b1;
      end
    endcase
  end

endmodule

// File: logic/bcd_wb_decode.sv
`timescale 1ns/10ps

`include "bcd_conv_macros.svh"

module bcd_wb_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`WB_ADR_W-1:0]  wb_adr,
  input  logic [`WB_DAT_W-1:0]  wb_dat_i,
  output logic [`WB_DAT_W-1:0]  wb_dat_o,
  output logic                  wb_ack,
  input  logic                  busy,
  input  bcd_conv_pkg::status_t status,
  input  logic [`BIN_W-1:0]     result,
  output logic                  start,
  output logic                  bad_digit,
  output logic [`BCD_W-1:0]     bcd_word
);

  logic req;
  logic data_wr;
  logic digit_bad;

  // a request is not taken in its own ack cycle, so ack drops between
  // back-to-back accesses.
  assign req = wb_cyc && wb_stb && !wb_ack;

  assign data_wr = req && wb_we && (wb_adr == `ADDR_DATA);

  always_comb begin
    digit_bad = 1'b0;
    for (int d = 0; d < `BCD_DIGITS; d++) begin
      if (wb_dat_i[4*d +: 4] > 4'd9) begin
        digit_bad = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // writes that arrive during a conversion are acknowledged and dropped.
  always_ff @(posedge clk) begin
    if (rst) begin
      start     <= 1'b0;
      bad_digit <= 1'b0;
    end else begin
      start     <= data_wr && !busy && !digit_bad;
      bad_digit <= data_wr && !busy && digit_bad;
    end
  end

  // only a word that starts a conversion is kept for read-back.
  always_ff @(posedge clk) begin
    if (rst) begin
      bcd_word <= '0;
    end else if (data_wr && !busy && !digit_bad) begin
      bcd_word <= wb_dat_i;
    end
  end

  // read data is registered together with ack.
  always_ff @(posedge clk) begin
    if (req && !wb_we) begin
      case (wb_adr)
        `ADDR_DATA:   wb_dat_o <= bcd_word;
        `ADDR_STATUS: wb_dat_o <= {{(`WB_DAT_W - $bits(status)){1'b0}}, status};
        `ADDR_RESULT: wb_dat_o <= {{(`WB_DAT_W - `BIN_W){1'b0}}, result};
        default:      wb_dat_o <= '0;
      endcase
    end
  end

endmodule

// File: logic/conv_ctrl_if.sv
`timescale 1ns/10ps

interface conv_ctrl_if;

  // strobes from the FSM to the shift register.
  logic clear;
  logic load;
  logic shift;
  logic correct;

  // iteration bookkeeping, kept next to the FSM.
  logic last;
  logic iter_done;

  // high when some BCD digit is 8 or more.
  logic need_fix;

  modport control (
    output clear,
    output load,
    output shift,
    output correct,
    output last,
    output iter_done,
    input  need_fix
  );

  modport datapath (
    input  clear,
    input  load,
    input  shift,
    input  correct,
    output need_fix
  );

endinterface

// File: logic/bcd_conv_pkg.sv
package bcd_conv_pkg;

  // states of the conversion FSM.
  // one iteration is SHIFT, CHECK, an optional CORRECT, then ITER.
  typedef enum logic [2:0] {
    START   = 3'd0,
    SHIFT   = 3'd1,
    CHECK   = 3'd2,
    CORRECT = 3'd3,
    ITER    = 3'd4,
    DONE    = 3'd5
  } conv_state_t;

  // status register contents, busy in the top bit.
  // reads return this word zero-extended to the bus width.
  typedef struct packed {
    logic busy;
    logic done;
    logic error;
  } status_t;

endpackage

// File: logic/bcd_conv_macros.svh
`ifndef BCD_CONV_MACROS_SVH
`define BCD_CONV_MACROS_SVH

// operand and result sizes.
`define BCD_DIGITS 4
`define BCD_W      16
`define BIN_W      14

// one shift per BCD bit, counted down from ITERS.
`define ITERS      16
`define ITER_W     5

// bus widths.
`define WB_ADR_W   2
`define WB_DAT_W   16

// register word addresses.
`define ADDR_DATA   2'd0
`define ADDR_STATUS 2'd1
`define ADDR_RESULT 2'd2

`endif
